// ==== common/adxl_spi_pkg.sv ====
package adxl_spi_pkg;

   // SPI link, mode 0, one byte per transfer unit
   localparam int spi_byte_bits = 8;

   typedef logic [spi_byte_bits-1:0] spi_byte_t;

   // command bytes, first byte after cs_b falls
   localparam spi_byte_t cmd_write = 8'h0A;
   localparam spi_byte_t cmd_read  = 8'h0B;
   localparam spi_byte_t cmd_fifo  = 8'h0D;

endpackage

// ==== common/adxl_reg_pkg.sv ====
package adxl_reg_pkg;

   localparam int addr_bits = 6;

   typedef logic [addr_bits-1:0] reg_addr_t;

   // read-only ID registers
   localparam reg_addr_t addr_devid_ad  = 6'h00;
   localparam reg_addr_t addr_devid_mst = 6'h01;
   localparam reg_addr_t addr_partid    = 6'h02;

   localparam logic [7:0] id_devid_ad  = 8'hAD;
   localparam logic [7:0] id_devid_mst = 8'h1D;
   localparam logic [7:0] id_partid    = 8'hF2;

   // fifo occupancy, read only
   localparam reg_addr_t addr_fifo_entries_l = 6'h0C;
   localparam reg_addr_t addr_fifo_entries_h = 6'h0D;

   // writable block
   localparam reg_addr_t addr_rw_first  = 6'h20;
   localparam reg_addr_t addr_rw_last   = 6'h2D;
   localparam reg_addr_t addr_power_ctl = 6'h2D;

   localparam logic [1:0] power_measure = 2'b10; // POWER_CTL[1:0]

   localparam logic [1:0] axis_x = 2'd0;
   localparam logic [1:0] axis_y = 2'd1;
   localparam logic [1:0] axis_z = 2'd2;

   // one fifo entry, sent lo byte first over SPI
   typedef union packed {
      struct packed {
         logic [7:0] hi;
         logic [7:0] lo;
      } bytes;
      struct packed {
         logic [1:0]  axis;
         logic [13:0] value;
      } fields;
   } fifo_entry_u;

endpackage

// ==== rtl/adxl_sample_gen.sv ====
`timescale 1ns/1ps

module adxl_sample_gen #(
   parameter int SAMPLE_DIV = 64
) (
   input  logic                      clk_sys,
   input  logic                      nCS,
   input  logic                      measure,
   input  logic                      full,
   output logic                      wr_en,
   output adxl_reg_pkg::fifo_entry_u wr_entry
);

   localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

   logic [DIV_W-1:0] div_cnt;
   logic             tick;
   logic             in_trip;  // triplet in progress
   logic [1:0]       axis_q;
   logic [13:0]      n_q;

   assign tick = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

   // stall on full, never drop an entry
   assign wr_en = in_trip & ~full;

   always_comb begin
      wr_entry.fields.axis  = axis_q;
      wr_entry.fields.value = n_q;
   end

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         div_cnt <= '0;
      end else if (!measure || tick) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         in_trip <= 1'b0;
         axis_q  <= adxl_reg_pkg::axis_x;
         n_q     <= '0;
      end else begin
         if (!in_trip) begin
            if (measure && tick) begin
               in_trip <= 1'b1;
            end
         end else if (wr_en) begin
            if (axis_q == adxl_reg_pkg::axis_z) begin
               // triplet done, next sample
               in_trip <= 1'b0;
               axis_q  <= adxl_reg_pkg::axis_x;
               n_q     <= n_q + 1'b1;  // wraps at 14 bits
            end else begin
               axis_q <= axis_q + 2'd1;
            end
         end
      end
   end

endmodule

// ==== rtl/adxl_sample_fifo.sv ====
`timescale 1ns/1ps

module adxl_sample_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                                clk_sys,
   input  logic                                nCS,
   input  logic                                wr_en,
   input  adxl_reg_pkg::fifo_entry_u           wr_entry,
   output logic                                full,
   input  logic                                pop,
   output adxl_reg_pkg::fifo_entry_u           rd_entry,
   output logic                                empty,
   output logic [$clog2(FIFO_DEPTH+1)-1:0]     count
);

   localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

   adxl_reg_pkg::fifo_entry_u mem [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_wr;
   logic             do_rd;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      ptr_next = (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full     = (count == COUNT_W'(FIFO_DEPTH));
   assign empty    = (count == '0);
   assign do_wr    = wr_en & ~full;
   assign do_rd    = pop & ~empty;   // pop on empty is dropped
   assign rd_entry = mem[rd_ptr];

   always_ff @(posedge clk_sys) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_entry;
      end
   end

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= ptr_next(wr_ptr);
         if (do_rd) rd_ptr <= ptr_next(rd_ptr);
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== rtl/adxl_reg_file.sv ====
`timescale 1ns/1ps

module adxl_reg_file #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                            clk_sys,
   input  logic                            nCS,
   input  adxl_reg_pkg::reg_addr_t         reg_addr,
   input  logic [7:0]                      reg_wdata,
   input  logic                            reg_we,
   output logic [7:0]                      reg_rdata,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0] count,
   output logic                            measure
);

   // 0x20..0x2D, THRESH_ACT up to POWER_CTL
   logic [7:0] rw_regs [adxl_reg_pkg::addr_rw_first:adxl_reg_pkg::addr_rw_last];

   logic        in_rw;
   logic [15:0] count_wide;

   assign in_rw = (reg_addr >= adxl_reg_pkg::addr_rw_first) &&
                  (reg_addr <= adxl_reg_pkg::addr_rw_last);

   assign count_wide = 16'(count);

   assign measure = (rw_regs[adxl_reg_pkg::addr_power_ctl][1:0] ==
                     adxl_reg_pkg::power_measure);

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         for (int i = adxl_reg_pkg::addr_rw_first; i <= adxl_reg_pkg::addr_rw_last; i++) begin
            rw_regs[i] <= 8'h00;
         end
      end else if (reg_we && in_rw) begin
         rw_regs[reg_addr] <= reg_wdata;  // ID / count writes fall through
      end
   end

   always_comb begin
      case (reg_addr)
         adxl_reg_pkg::addr_devid_ad: begin
            reg_rdata = adxl_reg_pkg::id_devid_ad;
         end
         adxl_reg_pkg::addr_devid_mst: begin
            reg_rdata = adxl_reg_pkg::id_devid_mst;
         end
         adxl_reg_pkg::addr_partid: begin
            reg_rdata = adxl_reg_pkg::id_partid;
         end
         adxl_reg_pkg::addr_fifo_entries_l: begin
            reg_rdata = count_wide[7:0];
         end
         adxl_reg_pkg::addr_fifo_entries_h: begin
            reg_rdata = count_wide[15:8];
         end
         default: begin
            // unmapped reads as zero
            reg_rdata = in_rw ? rw_regs[reg_addr] : 8'h00;
         end
      endcase
   end

endmodule

// ==== adxl_spi_slave/adxl_spi_shifter.sv ====
`timescale 1ns/1ps

module adxl_spi_shifter (
   input  logic                    clk_sys,
   input  logic                    nCS,
   input  logic                    sclk,
   input  logic                    mosi,
   input  logic                    cs_b,
   output logic                    miso,
   output logic                    active,
   output logic                    byte_start,
   output logic                    byte_done,
   output adxl_spi_pkg::spi_byte_t rx_byte,
   input  adxl_spi_pkg::spi_byte_t tx_byte
);

   localparam int MSB   = adxl_spi_pkg::spi_byte_bits - 1;
   localparam int CNT_W = $clog2(adxl_spi_pkg::spi_byte_bits);

   logic [2:0]               sclk_sync;  // two sync flops plus previous
   logic [2:0]               cs_sync;
   logic [1:0]               mosi_sync;
   logic                     sclk_rise;
   logic                     sclk_fall;
   logic                     cs_fall;
   logic                     fall_q;
   logic                     cs_fall_q;
   logic [CNT_W-1:0]         bit_cnt;
   adxl_spi_pkg::spi_byte_t  tx_sr;

   assign sclk_rise  = sclk_sync[1] & ~sclk_sync[2];
   assign sclk_fall  = ~sclk_sync[1] & sclk_sync[2];
   assign cs_fall    = ~cs_sync[1] & cs_sync[2];
   assign active     = ~cs_sync[1];
   assign byte_start = active & (cs_fall_q | (fall_q & (bit_cnt == '0)));

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         sclk_sync <= 3'b000;
         cs_sync   <= 3'b111;  // deselected
         mosi_sync <= 2'b00;
      end else begin
         sclk_sync <= {sclk_sync[1:0], sclk};
         cs_sync   <= {cs_sync[1:0], cs_b};
         mosi_sync <= {mosi_sync[0], mosi};
      end
   end

   // edge pulses delayed once so miso moves 3 cycles after the pin
   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         fall_q    <= 1'b0;
         cs_fall_q <= 1'b0;
         byte_done <= 1'b0;
         bit_cnt   <= '0;
         miso      <= 1'b0;
      end else begin
         fall_q    <= active & sclk_fall;
         cs_fall_q <= cs_fall;
         byte_done <= active & sclk_rise & (bit_cnt == CNT_W'(MSB));
         if (!active) begin
            bit_cnt <= '0;
            miso    <= 1'b0;
         end else begin
            if (sclk_rise) bit_cnt <= bit_cnt + 1'b1;
            if (byte_start) begin
               miso <= tx_byte[MSB];
            end else if (fall_q) begin
               miso <= tx_sr[MSB];
            end
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (active && sclk_rise) rx_byte <= {rx_byte[MSB-1:0], mosi_sync[1]};
      if (byte_start) begin
         tx_sr <= tx_byte << 1;
      end else if (fall_q) begin
         tx_sr <= tx_sr << 1;
      end
   end

endmodule

// ==== adxl_spi_slave/adxl_spi_slave.sv ====
`timescale 1ns/1ps

module adxl_spi_slave (
   input  logic                      clk_sys,
   input  logic                      nCS,
   input  logic                      sclk,
   input  logic                      mosi,
   input  logic                      cs_b,
   output logic                      miso,
   output adxl_reg_pkg::reg_addr_t   reg_addr,
   output logic [7:0]                reg_wdata,
   output logic                      reg_we,
   input  logic [7:0]                reg_rdata,
   input  adxl_reg_pkg::fifo_entry_u rd_entry,
   input  logic                      empty,
   output logic                      pop
);

   localparam logic [2:0] st_cmd     = 3'd0;
   localparam logic [2:0] st_addr    = 3'd1;
   localparam logic [2:0] st_wdata   = 3'd2;
   localparam logic [2:0] st_rdata   = 3'd3;
   localparam logic [2:0] st_fifo_lo = 3'd4;
   localparam logic [2:0] st_fifo_hi = 3'd5;
   localparam logic [2:0] st_ignore  = 3'd6;

   logic [2:0]                state;
   logic                      is_write;     // write vs read burst
   logic                      entry_valid;  // latched entry came from the fifo
   adxl_reg_pkg::fifo_entry_u entry_q;

   logic                      active;
   logic                      byte_start;
   logic                      byte_done;
   adxl_spi_pkg::spi_byte_t   rx_byte;
   adxl_spi_pkg::spi_byte_t   tx_byte;

   adxl_spi_shifter u_shifter (
      .clk_sys    (clk_sys),
      .nCS        (nCS),
      .sclk       (sclk),
      .mosi       (mosi),
      .cs_b       (cs_b),
      .miso       (miso),
      .active     (active),
      .byte_start (byte_start),
      .byte_done  (byte_done),
      .rx_byte    (rx_byte),
      .tx_byte    (tx_byte)
   );

   // reply byte, sampled by the shifter at byte_start
   always_comb begin
      case (state)
         st_rdata: begin
            tx_byte = reg_rdata;
         end
         st_fifo_lo: begin
            tx_byte = empty ? 8'h00 : rd_entry.bytes.lo;
         end
         st_fifo_hi: begin
            tx_byte = entry_q.bytes.hi;
         end
         default: begin
            tx_byte = 8'h00;
         end
      endcase
   end

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         state       <= st_cmd;
         is_write    <= 1'b0;
         entry_valid <= 1'b0;
         reg_addr    <= '0;
         reg_we      <= 1'b0;
         pop         <= 1'b0;
      end else begin
         reg_we <= 1'b0;
         pop    <= 1'b0;
         if (reg_we) begin
            reg_addr <= reg_addr + 1'b1;  // burst write, wraps at 6 bits
         end
         if (!active) begin
            state <= st_cmd;
         end else begin
            case (state)
               st_cmd: begin
                  if (byte_done) begin
                     if (rx_byte == adxl_spi_pkg::cmd_write) begin
                        is_write <= 1'b1;
                        state    <= st_addr;
                     end else if (rx_byte == adxl_spi_pkg::cmd_read) begin
                        is_write <= 1'b0;
                        state    <= st_addr;
                     end else if (rx_byte == adxl_spi_pkg::cmd_fifo) begin
                        state <= st_fifo_lo;
                     end else begin
                        state <= st_ignore;  // until cs_b rises
                     end
                  end
               end
               st_addr: begin
                  if (byte_done) begin
                     reg_addr <= rx_byte[adxl_reg_pkg::addr_bits-1:0];
                     state    <= is_write ? st_wdata : st_rdata;
                  end
               end
               st_wdata: begin
                  if (byte_done) reg_we <= 1'b1;
               end
               st_rdata: begin
                  if (byte_done) reg_addr <= reg_addr + 1'b1;
               end
               st_fifo_lo: begin
                  if (byte_start) entry_valid <= ~empty;
                  if (byte_done) state <= st_fifo_hi;
               end
               st_fifo_hi: begin
                  if (byte_done) begin
                     pop   <= entry_valid;  // no pop for the 0x0000 filler
                     state <= st_fifo_lo;
                  end
               end
               default: begin
                  state <= st_ignore;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (state == st_wdata && byte_done) reg_wdata <= rx_byte;
      // whole entry held for the hi byte
      if (state == st_fifo_lo && byte_start) entry_q <= empty ? 16'h0000 : rd_entry;
   end

endmodule

// ==== rtl/adxl362_top.sv ====
`timescale 1ns/1ps

module adxl362_top #(
   parameter int FIFO_DEPTH = 16,
   parameter int SAMPLE_DIV = 64
) (
   input  logic clk_sys,
   input  logic nCS,
   input  logic sclk,
   input  logic mosi,
   input  logic cs_b,
   output logic miso
);

   localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

   logic                      measure;
   logic                      full;
   logic                      wr_en;
   adxl_reg_pkg::fifo_entry_u wr_entry;
   adxl_reg_pkg::fifo_entry_u rd_entry;
   logic                      empty;
   logic                      pop;
   logic [COUNT_W-1:0]        count;
   adxl_reg_pkg::reg_addr_t   reg_addr;
   logic [7:0]                reg_wdata;
   logic [7:0]                reg_rdata;
   logic                      reg_we;

   adxl_sample_gen #(.SAMPLE_DIV(SAMPLE_DIV)) u_gen (
      .clk_sys  (clk_sys),
      .nCS      (nCS),
      .measure  (measure),
      .full     (full),
      .wr_en    (wr_en),
      .wr_entry (wr_entry)
   );

   adxl_sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk_sys  (clk_sys),
      .nCS      (nCS),
      .wr_en    (wr_en),
      .wr_entry (wr_entry),
      .full     (full),
      .pop      (pop),
      .rd_entry (rd_entry),
      .empty    (empty),
      .count    (count)
   );

   adxl_reg_file #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
      .clk_sys   (clk_sys),
      .nCS       (nCS),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_we    (reg_we),
      .reg_rdata (reg_rdata),
      .count     (count),
      .measure   (measure)
   );

   adxl_spi_slave u_slave (
      .clk_sys   (clk_sys),
      .nCS       (nCS),
      .sclk      (sclk),
      .mosi      (mosi),
      .cs_b      (cs_b),
      .miso      (miso),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_we    (reg_we),
      .reg_rdata (reg_rdata),
      .rd_entry  (rd_entry),
      .empty     (empty),
      .pop       (pop)
   );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS = 4
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

endmodule

// ==== tests/adxl362_tb.sv ====
`timescale 1ns/1ps

module adxl362_tb;

   localparam int FIFO_DEPTH = 16;
   localparam int SAMPLE_DIV = 256;  // one write transaction spans under 2 periods
   localparam int HALF       = 8;    // sclk half period in clk_sys cycles
   localparam int EST_BYTES  = 260;
   localparam int MEAS_WAIT  = 12 * SAMPLE_DIV;
   localparam int LIMIT      = 2 * (EST_BYTES * 8 * 2 * HALF + MEAS_WAIT);

   logic clk_sys;
   logic nCS;
   logic sclk;
   logic mosi;
   logic cs_b;
   logic miso;

   int          cycles;
   int          n_pass;
   int          n_fail;
   int          errs;      // errors in the running test
   logic [31:0] rng;
   logic [1:0]  exp_axis;  // next sample the producer should deliver
   logic [13:0] exp_n;
   adxl_spi_pkg::spi_byte_t shadow [13];  // expected contents of 0x20..0x2C

   tb_clock #(.PERIOD_NS(4)) u_clk (
      .clk (clk_sys)
   );

   adxl362_top #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .SAMPLE_DIV (SAMPLE_DIV)
   ) u_dut (
      .clk_sys (clk_sys),
      .nCS     (nCS),
      .sclk    (sclk),
      .mosi    (mosi),
      .cs_b    (cs_b),
      .miso    (miso)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic tick(input int n);
      repeat (n) @(posedge clk_sys);
      #1;
   endtask

   task automatic spi_bits(input adxl_spi_pkg::spi_byte_t tx, input int nbits,
                           output adxl_spi_pkg::spi_byte_t rx);
      rx = '0;
      for (int i = 7; i > 7 - nbits; i--) begin
         mosi = tx[i];
         tick(HALF);
         rx[i] = miso;  // steady at the rising edge
         sclk  = 1'b1;
         tick(HALF);
         sclk  = 1'b0;
      end
   endtask

   task automatic spi_byte(input adxl_spi_pkg::spi_byte_t tx,
                           output adxl_spi_pkg::spi_byte_t rx);
      spi_bits(tx, 8, rx);
   endtask

   task automatic spi_select();
      cs_b = 1'b0;
      tick(HALF);
   endtask

   task automatic spi_deselect();
      tick(HALF);
      cs_b = 1'b1;
      tick(2 * HALF);
   endtask

   task automatic reg_write_burst(input adxl_reg_pkg::reg_addr_t addr,
                                  input adxl_spi_pkg::spi_byte_t data[$]);
      adxl_spi_pkg::spi_byte_t rx;
      spi_select();
      spi_byte(adxl_spi_pkg::cmd_write, rx);
      spi_byte({2'b00, addr}, rx);
      foreach (data[i]) spi_byte(data[i], rx);
      spi_deselect();
   endtask

   task automatic reg_write_byte(input adxl_reg_pkg::reg_addr_t addr,
                                 input adxl_spi_pkg::spi_byte_t b);
      adxl_spi_pkg::spi_byte_t q[$];
      q.push_back(b);
      reg_write_burst(addr, q);
   endtask

   task automatic reg_read(input adxl_reg_pkg::reg_addr_t addr, input int n,
                           output adxl_spi_pkg::spi_byte_t data[$]);
      adxl_spi_pkg::spi_byte_t rx;
      data.delete();
      spi_select();
      spi_byte(adxl_spi_pkg::cmd_read, rx);
      spi_byte({2'b00, addr}, rx);
      for (int i = 0; i < n; i++) begin
         spi_byte(8'h00, rx);
         data.push_back(rx);
      end
      spi_deselect();
   endtask

   task automatic read_count(output int c);
      adxl_spi_pkg::spi_byte_t q[$];
      reg_read(6'h0C, 2, q);
      c = {q[1], q[0]};
   endtask

   // lo byte first, then hi
   task automatic fifo_read(input int n, output adxl_reg_pkg::fifo_entry_u e[$]);
      adxl_spi_pkg::spi_byte_t lo;
      adxl_spi_pkg::spi_byte_t hi;
      e.delete();
      spi_select();
      spi_byte(adxl_spi_pkg::cmd_fifo, lo);
      for (int i = 0; i < n; i++) begin
         spi_byte(8'h00, lo);
         spi_byte(8'h00, hi);
         e.push_back({hi, lo});
      end
      spi_deselect();
   endtask

   task automatic check_byte(input string name, input adxl_spi_pkg::spi_byte_t exp,
                             input adxl_spi_pkg::spi_byte_t act);
      if (act !== exp) begin
         $display("ERROR %s expected 0x%02h actual 0x%02h", name, exp, act);
         errs++;
      end
   endtask

   task automatic check_entry(input string name, input adxl_reg_pkg::fifo_entry_u exp,
                              input adxl_reg_pkg::fifo_entry_u act);
      if (act !== exp) begin
         $display("ERROR %s expected 0x%04h actual 0x%04h", name, exp, act);
         errs++;
      end
   endtask

   // X, Y, Z of sample n, then n+1
   task automatic check_stream(input adxl_reg_pkg::fifo_entry_u e[$]);
      adxl_reg_pkg::fifo_entry_u exp_e;
      foreach (e[i]) begin
         exp_e.fields.axis  = exp_axis;
         exp_e.fields.value = exp_n;
         check_entry($sformatf("fifo_entry[%0d]", i), exp_e, e[i]);
         if (exp_axis == 2'd2) begin
            exp_axis = 2'd0;
            exp_n    = exp_n + 1'b1;
         end else begin
            exp_axis = exp_axis + 2'd1;
         end
      end
   endtask

   task automatic check_triplets(input int c);
      if (c == 0 || c % 3 != 0 || c > FIFO_DEPTH) begin
         $display("entry count %0d is not a whole number of triplets within depth", c);
         errs++;
      end
   endtask

   task automatic finish_test(input string name);
      if (errs == 0) begin
         n_pass++;
         $display("PASS %s", name);
      end else begin
         n_fail++;
         $display("FAIL %s with %0d errors", name, errs);
      end
      errs = 0;
   endtask

   task automatic test_reset_ids();
      adxl_spi_pkg::spi_byte_t q[$];
      reg_read(6'h00, 3, q);
      check_byte("devid_ad", 8'hAD, q[0]);
      check_byte("devid_mst", 8'h1D, q[1]);
      check_byte("partid", 8'hF2, q[2]);
      reg_read(6'h0C, 2, q);
      check_byte("fifo_entries_l", 8'h00, q[0]);
      check_byte("fifo_entries_h", 8'h00, q[1]);
      finish_test("reset_ids");
   endtask

   task automatic test_burst_rw();
      adxl_spi_pkg::spi_byte_t wq[$];
      adxl_spi_pkg::spi_byte_t rq[$];
      for (int i = 0; i < 13; i++) begin
         rng       = xorshift32(rng);
         shadow[i] = rng[7:0];
         wq.push_back(rng[7:0]);
      end
      reg_write_burst(6'h20, wq);
      reg_read(6'h20, 13, rq);
      foreach (rq[i]) check_byte($sformatf("reg[0x%02h]", 8'h20 + i), shadow[i], rq[i]);
      finish_test("burst_rw");
   endtask

   task automatic test_ignored_writes();
      adxl_spi_pkg::spi_byte_t q[$];
      adxl_spi_pkg::spi_byte_t rx;
      reg_write_byte(6'h00, 8'h55);
      reg_write_byte(6'h10, 8'hA5);
      reg_read(6'h00, 1, q);
      check_byte("devid_ad", 8'hAD, q[0]);
      reg_read(6'h10, 1, q);
      check_byte("reg[0x10]", 8'h00, q[0]);
      spi_select();
      spi_byte(8'h42, rx);  // not a command
      spi_byte(8'h20, rx);
      spi_byte(~shadow[0], rx);
      spi_deselect();
      reg_read(6'h20, 13, q);
      foreach (q[i]) check_byte($sformatf("reg[0x%02h]", 8'h20 + i), shadow[i], q[i]);
      finish_test("ignored_writes");
   endtask

   task automatic test_measure();
      adxl_reg_pkg::fifo_entry_u e[$];
      int                        c;
      reg_write_byte(6'h2D, 8'h02);
      tick(3 * SAMPLE_DIV);
      reg_write_byte(6'h2D, 8'h00);
      read_count(c);
      check_triplets(c);
      fifo_read(c, e);
      check_stream(e);
      fifo_read(1, e);
      check_entry("fifo_entry_empty", 16'h0000, e[0]);
      finish_test("measure");
   endtask

   task automatic test_backpressure();
      adxl_spi_pkg::spi_byte_t   q[$];
      adxl_reg_pkg::fifo_entry_u e[$];
      int                        c;
      reg_write_byte(6'h2D, 8'h02);
      tick(7 * SAMPLE_DIV);
      reg_read(6'h0C, 2, q);
      check_byte("fifo_entries_l", 8'(FIFO_DEPTH), q[0]);
      check_byte("fifo_entries_h", 8'h00, q[1]);
      reg_write_byte(6'h2D, 8'h00);
      // the stalled triplet finishes while draining
      for (int r = 0; r < 4; r++) begin
         read_count(c);
         if (c == 0) break;
         fifo_read(c, e);
         check_stream(e);
      end
      if (c != 0) begin
         $display("FIFO still holds %0d entries after draining", c);
         errs++;
      end
      reg_write_byte(6'h2D, 8'h02);
      tick(2 * SAMPLE_DIV);
      reg_write_byte(6'h2D, 8'h00);
      read_count(c);
      check_triplets(c);
      fifo_read(c, e);
      check_stream(e);
      finish_test("backpressure");
   endtask

   task automatic test_cs_abort();
      adxl_spi_pkg::spi_byte_t q[$];
      adxl_spi_pkg::spi_byte_t rx;
      adxl_spi_pkg::spi_byte_t b0;
      adxl_spi_pkg::spi_byte_t b1;
      rng = xorshift32(rng);
      b0  = rng[7:0];
      b1  = rng[15:8];
      spi_select();
      spi_byte(adxl_spi_pkg::cmd_write, rx);
      spi_byte(8'h20, rx);
      spi_byte(b0, rx);
      spi_byte(b1, rx);
      spi_bits(~shadow[2], 4, rx);  // cut off mid byte
      spi_deselect();
      shadow[0] = b0;
      shadow[1] = b1;
      reg_read(6'h20, 3, q);
      foreach (q[i]) check_byte($sformatf("reg[0x%02h]", 8'h20 + i), shadow[i], q[i]);
      finish_test("cs_abort");
   endtask

   initial begin
      cycles = 0;
      while (cycles < LIMIT) begin
         @(posedge clk_sys);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Verification failed");
      $finish;
   end

   initial begin
      nCS      = 1'b1;
      sclk     = 1'b0;
      mosi     = 1'b0;
      cs_b     = 1'b1;
      rng      = 32'h07ad_2ff5;
      errs     = 0;
      n_pass   = 0;
      n_fail   = 0;
      exp_axis = 2'd0;
      exp_n    = '0;
      repeat (16) @(posedge clk_sys);
      #1 nCS = 1'b0;
      tick(4);
      test_reset_ids();
      test_burst_rw();
      test_ignored_writes();
      test_measure();
      test_backpressure();
      test_cs_abort();
      $display("tests passed %0d, tests failed %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== adxl362.f ====
common/adxl_spi_pkg.sv
common/adxl_reg_pkg.sv
rtl/adxl_sample_gen.sv
rtl/adxl_sample_fifo.sv
rtl/adxl_reg_file.sv
adxl_spi_slave/adxl_spi_shifter.sv
adxl_spi_slave/adxl_spi_slave.sv
rtl/adxl362_top.sv
tests/tb_clock.sv
tests/adxl362_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = adxl362_tb
FILELIST  = adxl362.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status comes from the search for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
